/* soc_defs.svh */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths
`define SOC_ADDR_W     8
`define SOC_DATA_W     32

// pin groups
`define SOC_SW_W       16
`define SOC_BTN_W      5
`define SOC_ROPE_W     10

// cycles an input must hold before it is accepted
`define SOC_DB_CYCLES  16

// address bit 4 picks the slave, 0 gpio and 1 rope
`define SOC_SEL_BIT    4

// register offsets
`define SOC_GPIO_OUT   8'h00
`define SOC_GPIO_OE    8'h04
`define SOC_GPIO_IN    8'h08
`define SOC_ROPE_LOC   8'h10
`define SOC_ROPE_BTN   8'h14

`endif

/* soc_pkg.sv */
`include "soc_defs.svh"

package soc_pkg;

   // bus vectors
   typedef logic [`SOC_ADDR_W-1:0] wb_addr_t;
   typedef logic [`SOC_DATA_W-1:0] wb_data_t;

   // board inputs and outputs
   typedef logic [`SOC_SW_W-1:0]   sw_t;
   typedef logic [`SOC_BTN_W-1:0]  btn_t;
   typedef logic [`SOC_ROPE_W-1:0] rope_loc_t;

   // arbiter grant state
   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_M0,
      ARB_M1
   } arb_state_e;

endpackage

/* wb_interconnect.sv */
`include "soc_defs.svh"

module wb_interconnect (
   input  logic               clk,
   input  logic               i_arst_n,
   // master 0
   input  logic               i_m0_cyc,
   input  logic               i_m0_stb,
   input  logic               i_m0_we,
   input  soc_pkg::wb_addr_t  i_m0_adr,
   input  soc_pkg::wb_data_t  i_m0_dat,
   output soc_pkg::wb_data_t  o_m0_dat,
   output logic               o_m0_ack,
   // master 1
   input  logic               i_m1_cyc,
   input  logic               i_m1_stb,
   input  logic               i_m1_we,
   input  soc_pkg::wb_addr_t  i_m1_adr,
   input  soc_pkg::wb_data_t  i_m1_dat,
   output soc_pkg::wb_data_t  o_m1_dat,
   output logic               o_m1_ack,
   // slave side
   output logic               o_gpio_stb,
   output logic               o_rope_stb,
   output logic               o_s_we,
   output soc_pkg::wb_addr_t  o_s_adr,
   output soc_pkg::wb_data_t  o_s_dat,
   input  soc_pkg::wb_data_t  i_gpio_dat,
   input  soc_pkg::wb_data_t  i_rope_dat,
   input  logic               i_gpio_ack,
   input  logic               i_rope_ack
);

   soc_pkg::arb_state_e state;
   soc_pkg::arb_state_e state_nxt;
   logic                last_m1;
   logic                m0_req;
   logic                m1_req;
   logic                grant_m0;
   logic                grant_m1;
   logic                stb_g;
   logic                sel_rope;
   logic                sel_ack;
   soc_pkg::wb_data_t   sel_dat;
   soc_pkg::wb_addr_t   adr_g;

   assign m0_req = i_m0_cyc & i_m0_stb;
   assign m1_req = i_m1_cyc & i_m1_stb;

   // *********************************************************
   // round robin arbiter
   // *********************************************************
   always_comb begin
      state_nxt = state;
      case (state)
         soc_pkg::ARB_IDLE: begin
            if (m0_req && m1_req) begin
               // the loser of the last round goes first
               state_nxt = last_m1 ? soc_pkg::ARB_M0 : soc_pkg::ARB_M1;
            end else if (m0_req) begin
               state_nxt = soc_pkg::ARB_M0;
            end else if (m1_req) begin
               state_nxt = soc_pkg::ARB_M1;
            end
         end
         soc_pkg::ARB_M0: begin
            if (!i_m0_cyc) begin
               state_nxt = soc_pkg::ARB_IDLE;
            end
         end
         soc_pkg::ARB_M1: begin
            if (!i_m1_cyc) begin
               state_nxt = soc_pkg::ARB_IDLE;
            end
         end
         default: state_nxt = soc_pkg::ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state   <= soc_pkg::ARB_IDLE;
         last_m1 <= 1'b1;
      end else begin
         state <= state_nxt;
         if (state == soc_pkg::ARB_IDLE && state_nxt == soc_pkg::ARB_M0) begin
            last_m1 <= 1'b0;
         end else if (state == soc_pkg::ARB_IDLE && state_nxt == soc_pkg::ARB_M1) begin
            last_m1 <= 1'b1;
         end
      end
   end

   assign grant_m0 = (state == soc_pkg::ARB_M0);
   assign grant_m1 = (state == soc_pkg::ARB_M1);

   // *********************************************************
   // shared slave lines and decode
   // *********************************************************
   assign adr_g   = grant_m1 ? i_m1_adr : i_m0_adr;
   assign o_s_adr = {adr_g[`SOC_ADDR_W-1:2], 2'b00};
   assign o_s_we  = grant_m1 ? i_m1_we : i_m0_we;
   assign o_s_dat = grant_m1 ? i_m1_dat : i_m0_dat;

   assign stb_g    = (grant_m0 & m0_req) | (grant_m1 & m1_req);
   assign sel_rope = adr_g[`SOC_SEL_BIT];

   assign o_gpio_stb = stb_g & ~sel_rope;
   assign o_rope_stb = stb_g & sel_rope;

   // response goes back to the granted master only
   assign sel_ack = sel_rope ? i_rope_ack : i_gpio_ack;
   assign sel_dat = sel_rope ? i_rope_dat : i_gpio_dat;

   assign o_m0_ack = grant_m0 & sel_ack;
   assign o_m1_ack = grant_m1 & sel_ack;
   assign o_m0_dat = grant_m0 ? sel_dat : '0;
   assign o_m1_dat = grant_m1 ? sel_dat : '0;

endmodule

/* debounce.sv */
`include "soc_defs.svh"

module debounce #(
   parameter int WIDTH = 16
) (
   input  logic             clk,
   input  logic             i_arst_n,
   input  logic [WIDTH-1:0] i_raw,
   output logic [WIDTH-1:0] o_stable
);

   localparam int                CNT_W   = $clog2(`SOC_DB_CYCLES + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`SOC_DB_CYCLES - 1);

   logic [WIDTH-1:0] sync_q1;
   logic [WIDTH-1:0] sync_q2;
   logic [WIDTH-1:0] last;
   logic [CNT_W-1:0] cnt;
   logic             same;

   assign same = (sync_q2 == last);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sync_q1  <= '0;
         sync_q2  <= '0;
         last     <= '0;
         cnt      <= '0;
         o_stable <= '0;
      end else begin
         // two stage synchroniser
         sync_q1 <= i_raw;
         sync_q2 <= sync_q1;
         last    <= sync_q2;
         if (!same) begin
            cnt <= '0;
         end else if (cnt != CNT_MAX) begin
            cnt <= cnt + 1'b1;
         end
         // held long enough, let it through
         if (same && cnt == CNT_MAX) begin
            o_stable <= last;
         end
      end
   end

endmodule

/* gpio_regs.sv */
`include "soc_defs.svh"

module gpio_regs (
   input  logic                                clk,
   input  logic                                i_arst_n,
   input  logic                                i_stb,
   input  logic                                i_we,
   input  soc_pkg::wb_addr_t                   i_adr,
   input  soc_pkg::wb_data_t                   i_dat,
   input  soc_pkg::sw_t                        i_sw_db,
   input  logic [`SOC_DATA_W-`SOC_SW_W-1:0]    i_pins_lo,
   output soc_pkg::wb_data_t                   o_dat,
   output logic                                o_ack,
   output soc_pkg::wb_data_t                   o_gpio_out,
   output soc_pkg::wb_data_t                   o_gpio_oe
);

   logic wr_en;

   // one write per strobe, on the ack edge
   assign wr_en = i_stb & i_we & ~o_ack;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ack      <= 1'b0;
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
      end else begin
         o_ack <= i_stb & ~o_ack;
         if (wr_en && i_adr == `SOC_GPIO_OUT) begin
            o_gpio_out <= i_dat;
         end
         if (wr_en && i_adr == `SOC_GPIO_OE) begin
            o_gpio_oe <= i_dat;
         end
      end
   end

   // readback, switches sit above the raw low pins
   always_comb begin
      case (i_adr)
         `SOC_GPIO_OUT: o_dat = o_gpio_out;
         `SOC_GPIO_OE:  o_dat = o_gpio_oe;
         `SOC_GPIO_IN:  o_dat = {i_sw_db, i_pins_lo};
         default:       o_dat = '0;
      endcase
   end

endmodule

/* rope_regs.sv */
`include "soc_defs.svh"

module rope_regs (
   input  logic                clk,
   input  logic                i_arst_n,
   input  logic                i_stb,
   input  logic                i_we,
   input  soc_pkg::wb_addr_t   i_adr,
   input  soc_pkg::wb_data_t   i_dat,
   input  soc_pkg::btn_t       i_btn_db,
   output soc_pkg::wb_data_t   o_dat,
   output logic                o_ack,
   output soc_pkg::rope_loc_t  o_rope_loc
);

   logic wr_loc;

   assign wr_loc = i_stb & i_we & ~o_ack & (i_adr == `SOC_ROPE_LOC);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ack      <= 1'b0;
         o_rope_loc <= '0;
      end else begin
         o_ack <= i_stb & ~o_ack;
         // only the low bits of the location are kept
         if (wr_loc) begin
            o_rope_loc <= i_dat[`SOC_ROPE_W-1:0];
         end
      end
   end

   always_comb begin
      case (i_adr)
         `SOC_ROPE_LOC: o_dat = soc_pkg::wb_data_t'(o_rope_loc);
         `SOC_ROPE_BTN: o_dat = soc_pkg::wb_data_t'(i_btn_db);
         default:       o_dat = '0;
      endcase
   end

endmodule

/* periph_top.sv */
`include "soc_defs.svh"

module periph_top (
   input  logic                clk,
   input  logic                i_arst_n,
   // master 0
   input  logic                i_m0_cyc,
   input  logic                i_m0_stb,
   input  logic                i_m0_we,
   input  soc_pkg::wb_addr_t   i_m0_adr,
   input  soc_pkg::wb_data_t   i_m0_dat,
   output soc_pkg::wb_data_t   o_m0_dat,
   output logic                o_m0_ack,
   // master 1
   input  logic                i_m1_cyc,
   input  logic                i_m1_stb,
   input  logic                i_m1_we,
   input  soc_pkg::wb_addr_t   i_m1_adr,
   input  soc_pkg::wb_data_t   i_m1_dat,
   output soc_pkg::wb_data_t   o_m1_dat,
   output logic                o_m1_ack,
   // board pins
   input  soc_pkg::wb_data_t   i_gpio_in,
   input  soc_pkg::btn_t       i_btn,
   output soc_pkg::wb_data_t   o_gpio_out,
   output soc_pkg::wb_data_t   o_gpio_oe,
   output soc_pkg::sw_t        o_sw_db,
   output soc_pkg::rope_loc_t  o_rope_loc
);

   logic               gpio_stb;
   logic               rope_stb;
   logic               s_we;
   soc_pkg::wb_addr_t  s_adr;
   soc_pkg::wb_data_t  s_dat;
   soc_pkg::wb_data_t  gpio_dat;
   soc_pkg::wb_data_t  rope_dat;
   logic               gpio_ack;
   logic               rope_ack;
   soc_pkg::btn_t      btn_db;

   // *********************************************************
   // bus
   // *********************************************************
   wb_interconnect wb_interconnect_i (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_m0_cyc   (i_m0_cyc),
      .i_m0_stb   (i_m0_stb),
      .i_m0_we    (i_m0_we),
      .i_m0_adr   (i_m0_adr),
      .i_m0_dat   (i_m0_dat),
      .o_m0_dat   (o_m0_dat),
      .o_m0_ack   (o_m0_ack),
      .i_m1_cyc   (i_m1_cyc),
      .i_m1_stb   (i_m1_stb),
      .i_m1_we    (i_m1_we),
      .i_m1_adr   (i_m1_adr),
      .i_m1_dat   (i_m1_dat),
      .o_m1_dat   (o_m1_dat),
      .o_m1_ack   (o_m1_ack),
      .o_gpio_stb (gpio_stb),
      .o_rope_stb (rope_stb),
      .o_s_we     (s_we),
      .o_s_adr    (s_adr),
      .o_s_dat    (s_dat),
      .i_gpio_dat (gpio_dat),
      .i_rope_dat (rope_dat),
      .i_gpio_ack (gpio_ack),
      .i_rope_ack (rope_ack)
   );

   // *********************************************************
   // switch and button debounce
   // *********************************************************
   // switches live on the upper half of the gpio pins
   debounce #(.WIDTH(`SOC_SW_W)) sw_db_i (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_raw    (i_gpio_in[`SOC_DATA_W-1:`SOC_DATA_W-`SOC_SW_W]),
      .o_stable (o_sw_db)
   );

   debounce #(.WIDTH(`SOC_BTN_W)) btn_db_i (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_raw    (i_btn),
      .o_stable (btn_db)
   );

   // *********************************************************
   // slaves
   // *********************************************************
   gpio_regs gpio_regs_i (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_stb      (gpio_stb),
      .i_we       (s_we),
      .i_adr      (s_adr),
      .i_dat      (s_dat),
      .i_sw_db    (o_sw_db),
      .i_pins_lo  (i_gpio_in[`SOC_DATA_W-`SOC_SW_W-1:0]),
      .o_dat      (gpio_dat),
      .o_ack      (gpio_ack),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe)
   );

   rope_regs rope_regs_i (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_stb      (rope_stb),
      .i_we       (s_we),
      .i_adr      (s_adr),
      .i_dat      (s_dat),
      .i_btn_db   (btn_db),
      .o_dat      (rope_dat),
      .o_ack      (rope_ack),
      .o_rope_loc (o_rope_loc)
   );

endmodule

/* periph_checker.sv */
module periph_checker (
   input logic clk,
   input logic i_arst_n,
   input logic i_m0_stb,
   input logic i_m0_ack,
   input logic i_m1_stb,
   input logic i_m1_ack,
   input logic i_gpio_stb,
   input logic i_rope_stb,
   input logic i_gpio_ack,
   input logic i_rope_ack
);

   int assert_errors = 0;

   m0_ack_needs_stb: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_m0_ack |-> i_m0_stb) else begin
      $error("ack on master 0 without stb");
      assert_errors++;
   end

   m1_ack_needs_stb: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_m1_ack |-> i_m1_stb) else begin
      $error("ack on master 1 without stb");
      assert_errors++;
   end

   // one slave busy at a time
   one_slave_stb: assert property (@(posedge clk) disable iff (!i_arst_n)
      !(i_gpio_stb && (i_rope_stb || i_rope_ack)) && !(i_rope_stb && i_gpio_ack)) else begin
      $error("both slaves busy at once");
      assert_errors++;
   end

   // a slave ack is a single pulse that reaches exactly one master
   gpio_ack_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_gpio_ack |-> (i_m0_ack ^ i_m1_ack) ##1 !i_gpio_ack) else begin
      $error("gpio ack not a single pulse to one master");
      assert_errors++;
   end

   rope_ack_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rope_ack |-> (i_m0_ack ^ i_m1_ack) ##1 !i_rope_ack) else begin
      $error("rope ack not a single pulse to one master");
      assert_errors++;
   end

endmodule

bind periph_top periph_checker periph_checker_i (
   .clk        (clk),
   .i_arst_n   (i_arst_n),
   .i_m0_stb   (i_m0_stb),
   .i_m0_ack   (o_m0_ack),
   .i_m1_stb   (i_m1_stb),
   .i_m1_ack   (o_m1_ack),
   .i_gpio_stb (gpio_stb),
   .i_rope_stb (rope_stb),
   .i_gpio_ack (gpio_ack),
   .i_rope_ack (rope_ack)
);

/* tb_clkgen.sv */
module tb_clkgen (
   output logic o_clk,
   output logic o_arst_n
);

   initial begin
      o_clk = 1'b0;
      forever #5 o_clk = ~o_clk;
   end

   // reset held for 16 rising edges, released just after the last one
   initial begin
      o_arst_n = 1'b0;
      repeat (16) @(posedge o_clk);
      #1 o_arst_n = 1'b1;
   end

endmodule

/* tb_monitor.sv */
module tb_monitor (
   input logic clk,
   input logic i_arst_n,
   input logic i_m0_ack,
   input logic i_m1_ack
);

   int data_errors;
   int proto_errors;
   int ack_cnt0;
   int ack_cnt1;

   initial begin
      data_errors  = 0;
      proto_errors = 0;
      ack_cnt0     = 0;
      ack_cnt1     = 0;
   end

   // every ack lasts one cycle, so each high sample is one transfer
   always @(posedge clk) begin
      if (i_arst_n && i_m0_ack) begin
         ack_cnt0 <= ack_cnt0 + 1;
      end
      if (i_arst_n && i_m1_ack) begin
         ack_cnt1 <= ack_cnt1 + 1;
      end
   end

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         data_errors++;
         $display("FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic report_protocol(input string what);
      proto_errors++;
      $display("%s", what);
   endtask

endmodule

/* tb_periph.sv */
`include "soc_defs.svh"

module tb_periph;

   localparam int NUM_TESTS = 6;
   localparam int DB_WAIT   = `SOC_DB_CYCLES + 3;
   localparam int IDLE_LAT  = 2;
   // grant, ack, the edge that takes ack, and the edge the arbiter sees cyc fall
   localparam int XFER_CYCLES = IDLE_LAT + 2;

   logic               clk;
   logic               arst_n;
   logic               m0_cyc, m0_stb, m0_we, m0_ack;
   logic               m1_cyc, m1_stb, m1_we, m1_ack;
   soc_pkg::wb_addr_t  m0_adr, m1_adr;
   soc_pkg::wb_data_t  m0_wdat, m1_wdat, m0_rdat, m1_rdat;
   soc_pkg::wb_data_t  gpio_in;
   soc_pkg::btn_t      btn;
   soc_pkg::wb_data_t  gpio_out, gpio_oe;
   soc_pkg::sw_t       sw_db;
   soc_pkg::rope_loc_t rope_loc;

   // register file and pin model
   soc_pkg::wb_data_t  mdl_out, mdl_oe;
   soc_pkg::rope_loc_t mdl_loc;
   soc_pkg::sw_t       mdl_sw;
   soc_pkg::btn_t      mdl_btn;
   int                 exp_ack0, exp_ack1;
   logic               last_grant;
   integer             seed;

   tb_clkgen tb_clkgen_i (.o_clk(clk), .o_arst_n(arst_n));

   periph_top i_periph_top (
      .clk(clk), .i_arst_n(arst_n),
      .i_m0_cyc(m0_cyc), .i_m0_stb(m0_stb), .i_m0_we(m0_we), .i_m0_adr(m0_adr),
      .i_m0_dat(m0_wdat), .o_m0_dat(m0_rdat), .o_m0_ack(m0_ack),
      .i_m1_cyc(m1_cyc), .i_m1_stb(m1_stb), .i_m1_we(m1_we), .i_m1_adr(m1_adr),
      .i_m1_dat(m1_wdat), .o_m1_dat(m1_rdat), .o_m1_ack(m1_ack),
      .i_gpio_in(gpio_in), .i_btn(btn), .o_gpio_out(gpio_out), .o_gpio_oe(gpio_oe),
      .o_sw_db(sw_db), .o_rope_loc(rope_loc)
   );

   tb_monitor tb_monitor_i (
      .clk(clk), .i_arst_n(arst_n), .i_m0_ack(m0_ack), .i_m1_ack(m1_ack)
   );

   // expected read value from the model
   function automatic soc_pkg::wb_data_t exp_read(input soc_pkg::wb_addr_t adr);
      case (adr)
         `SOC_GPIO_OUT: return mdl_out;
         `SOC_GPIO_OE:  return mdl_oe;
         `SOC_GPIO_IN:  return {mdl_sw, gpio_in[`SOC_DATA_W-`SOC_SW_W-1:0]};
         `SOC_ROPE_LOC: return {{(`SOC_DATA_W-`SOC_ROPE_W){1'b0}}, mdl_loc};
         `SOC_ROPE_BTN: return {{(`SOC_DATA_W-`SOC_BTN_W){1'b0}}, mdl_btn};
         default:       return '0;
      endcase
   endfunction

   task automatic model_write(input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t d);
      if (adr == `SOC_GPIO_OUT) mdl_out = d;
      if (adr == `SOC_GPIO_OE) mdl_oe = d;
      if (adr == `SOC_ROPE_LOC) mdl_loc = d[`SOC_ROPE_W-1:0];
   endtask

   task automatic drive_master(input int m, input logic on, input logic we,
                               input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t d);
      if (m == 0) begin
         m0_cyc  = on;
         m0_stb  = on;
         m0_we   = we;
         m0_adr  = adr;
         m0_wdat = d;
      end else begin
         m1_cyc  = on;
         m1_stb  = on;
         m1_we   = we;
         m1_adr  = adr;
         m1_wdat = d;
      end
   endtask

   // one classic cycle, started 1 unit after a rising edge
   task automatic bus_xfer(input int m, input logic we, input soc_pkg::wb_addr_t adr,
                           input soc_pkg::wb_data_t wd, output soc_pkg::wb_data_t rd,
                           output int lat);
      logic ack;
      @(posedge clk);
      #1 drive_master(m, 1'b1, we, adr, wd);
      lat = 0;
      rd  = '0;
      ack = 1'b0;
      while (!ack && lat < 60) begin
         @(posedge clk);
         #1 lat++;
         ack = (m == 0) ? m0_ack : m1_ack;
      end
      if (ack) begin
         rd = (m == 0) ? m0_rdat : m1_rdat;
         last_grant = m[0];
         if (m == 0) exp_ack0++;
         else exp_ack1++;
      end else begin
         tb_monitor_i.report_protocol($sformatf("no ack for master %0d at address %h", m, adr));
      end
      // request stays up through the edge that takes the ack
      @(posedge clk);
      #1 drive_master(m, 1'b0, 1'b0, '0, '0);
   endtask

   task automatic do_write(input int m, input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t d,
                           output int lat);
      soc_pkg::wb_data_t rd;
      bus_xfer(m, 1'b1, adr, d, rd, lat);
      model_write(adr, d);
   endtask

   task automatic do_read(input int m, input soc_pkg::wb_addr_t adr, input string name);
      soc_pkg::wb_data_t rd;
      int                lat;
      bus_xfer(m, 1'b0, adr, '0, rd, lat);
      tb_monitor_i.compare(name, exp_read(adr), rd);
   endtask

   task automatic set_pins(input soc_pkg::wb_data_t pins, input soc_pkg::btn_t b);
      @(posedge clk);
      #1 gpio_in = pins;
      btn = b;
   endtask

   // watchdog sized from the test count
   initial begin
      #(NUM_TESTS * (4 * `SOC_DB_CYCLES + 40) * 10);
      $display("watchdog expired, the bus stopped answering");
      $display("tests failed");
      $finish;
   end

   initial begin
      int                l0, l1, lat, i;
      logic              winner;
      soc_pkg::wb_data_t d0, d1, r0, r1, pins;
      soc_pkg::wb_addr_t a0, a1;
      seed = 32'h5c18f658;
      drive_master(0, 1'b0, 1'b0, '0, '0);
      drive_master(1, 1'b0, 1'b0, '0, '0);
      gpio_in = '0;
      btn = '0;
      mdl_out = '0;
      mdl_oe = '0;
      mdl_loc = '0;
      mdl_sw = '0;
      mdl_btn = '0;
      exp_ack0 = 0;
      exp_ack1 = 0;
      last_grant = 1'b1;
      @(posedge arst_n);
      tb_monitor_i.compare("reset gpio_out", '0, gpio_out);
      tb_monitor_i.compare("reset gpio_oe", '0, gpio_oe);
      tb_monitor_i.compare("reset rope_loc", '0, 32'(rope_loc));
      tb_monitor_i.compare("reset m0 ack", '0, 32'(m0_ack));
      tb_monitor_i.compare("reset m1 ack", '0, 32'(m1_ack));

      // ************************************************************
      // 1 and 2, single masters on an idle bus
      // ************************************************************
      for (i = 0; i < 3; i++) begin
         do_write(0, `SOC_GPIO_OUT, $random(seed), lat);
         tb_monitor_i.compare("gpio ack latency", IDLE_LAT, lat);
         do_write(0, `SOC_GPIO_OE, $random(seed), lat);
         do_read(0, `SOC_GPIO_OUT, "gpio_out readback");
         do_read(0, `SOC_GPIO_OE, "gpio_oe readback");
         tb_monitor_i.compare("o_gpio_out", mdl_out, gpio_out);
         tb_monitor_i.compare("o_gpio_oe", mdl_oe, gpio_oe);
         do_write(1, `SOC_ROPE_LOC, $random(seed), lat);
         tb_monitor_i.compare("rope ack latency", IDLE_LAT, lat);
         do_read(1, `SOC_ROPE_LOC, "rope_loc readback");
         tb_monitor_i.compare("o_rope_loc", 32'(mdl_loc), 32'(rope_loc));
      end

      // ************************************************************
      // 3 and 4, debounce and a short glitch
      // ************************************************************
      pins = $random(seed);
      set_pins(pins, 5'h15);
      repeat (DB_WAIT) @(posedge clk);
      #1 mdl_sw = pins[`SOC_DATA_W-1:`SOC_DATA_W-`SOC_SW_W];
      mdl_btn = 5'h15;
      tb_monitor_i.compare("o_sw_db", 32'(mdl_sw), 32'(sw_db));
      do_read(0, `SOC_GPIO_IN, "gpio input word");
      do_read(1, `SOC_ROPE_BTN, "button word");
      // glitch the switches for half the debounce time
      set_pins(~pins, 5'h15);
      repeat (`SOC_DB_CYCLES / 2 - 1) begin
         @(posedge clk);
         #1 tb_monitor_i.compare("glitch o_sw_db", 32'(mdl_sw), 32'(sw_db));
      end
      set_pins(pins, 5'h15);
      repeat (DB_WAIT + 2) begin
         @(posedge clk);
         #1 tb_monitor_i.compare("glitch o_sw_db", 32'(mdl_sw), 32'(sw_db));
      end
      do_read(0, `SOC_GPIO_IN, "glitch input word");

      // ************************************************************
      // 5, both masters in the same cycle
      // ************************************************************
      for (i = 0; i < 4; i++) begin
         d0 = $random(seed);
         d1 = $random(seed);
         a0 = i[0] ? `SOC_ROPE_LOC : `SOC_GPIO_OUT;
         a1 = i[0] ? `SOC_GPIO_OE : `SOC_ROPE_LOC;
         winner = ~last_grant;
         fork
            bus_xfer(0, 1'b1, a0, d0, r0, l0);
            bus_xfer(1, 1'b1, a1, d1, r1, l1);
         join
         tb_monitor_i.compare("contention winner", 32'(winner), (l0 < l1) ? 0 : 1);
         tb_monitor_i.compare("winner latency", IDLE_LAT, (l0 < l1) ? l0 : l1);
         if (((l0 < l1) ? l1 : l0) > XFER_CYCLES + IDLE_LAT) begin
            tb_monitor_i.report_protocol("loser waited longer than one transfer plus two");
         end
         model_write(a0, d0);
         model_write(a1, d1);
      end
      do_read(0, `SOC_GPIO_OUT, "final gpio_out");
      do_read(1, `SOC_GPIO_OE, "final gpio_oe");
      do_read(0, `SOC_ROPE_LOC, "final rope_loc");

      // ************************************************************
      // 6, unmapped and read-only offsets
      // ************************************************************
      do_write(0, `SOC_GPIO_IN, $random(seed), lat);
      do_write(1, `SOC_ROPE_BTN, $random(seed), lat);
      do_write(0, 8'h0c, $random(seed), lat);
      do_write(1, 8'h1c, $random(seed), lat);
      do_read(0, `SOC_GPIO_IN, "read-only input word");
      do_read(1, `SOC_ROPE_BTN, "read-only button word");
      do_read(0, 8'h0c, "unmapped 0x0c");
      do_read(1, 8'h18, "unmapped 0x18");
      do_read(0, 8'h20, "unmapped 0x20");
      tb_monitor_i.compare("o_gpio_out unchanged", mdl_out, gpio_out);
      tb_monitor_i.compare("o_gpio_oe unchanged", mdl_oe, gpio_oe);
      tb_monitor_i.compare("o_rope_loc unchanged", 32'(mdl_loc), 32'(rope_loc));

      repeat (2) @(posedge clk);
      tb_monitor_i.compare("master 0 ack count", exp_ack0, tb_monitor_i.ack_cnt0);
      tb_monitor_i.compare("master 1 ack count", exp_ack1, tb_monitor_i.ack_cnt1);
      $display("errors: data %0d, protocol %0d, assertion %0d", tb_monitor_i.data_errors,
               tb_monitor_i.proto_errors, i_periph_top.periph_checker_i.assert_errors);
      if (tb_monitor_i.data_errors == 0 && tb_monitor_i.proto_errors == 0 &&
          i_periph_top.periph_checker_i.assert_errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* files.f */
+incdir+.
soc_pkg.sv
wb_interconnect.sv
debounce.sv
gpio_regs.sv
rope_regs.sv
periph_top.sv
periph_checker.sv
tb_clkgen.sv
tb_monitor.sv
tb_periph.sv

/* Bender.yml */
package:
  name: periph

sources:
  - include_dirs:
      - .
    files:
      - soc_pkg.sv
      - wb_interconnect.sv
      - debounce.sv
      - gpio_regs.sv
      - rope_regs.sv
      - periph_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - periph_checker.sv
      - tb_clkgen.sv
      - tb_monitor.sv
      - tb_periph.sv
